// File: source/cpu_cfg_pkg.sv
// Core-wide sizing constants
// Data width, reorder buffer size and reservation station depth

package cpu_cfg_pkg;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    // Integer register width
    localparam int unsigned XLEN = 32;

    // ----------------------------------------
    // Reorder buffer
    // ----------------------------------------
    // Number of in-flight instructions
    localparam int unsigned ROB_DEPTH = 16;
    // Bits of a ROB index
    localparam int unsigned ROB_IDX_LEN = $clog2(ROB_DEPTH);

    // ----------------------------------------
    // Reservation stations
    // ----------------------------------------
    // Entries in the operand-only station (power of two)
    localparam int unsigned RS_DEPTH = 4;

endpackage

// File: source/expipe_pkg.sv
// Execution pipeline types
// ROB index, exception codes, CDB payload and arbiter priority

package expipe_pkg;

    // Reorder buffer entry index
    typedef logic [cpu_cfg_pkg::ROB_IDX_LEN-1:0] rob_idx_t;

    // Exception causes carried on the CDB
    typedef enum logic [3:0] {
        E_NONE    = 4'h0,
        E_ILLEGAL = 4'h2,
        E_UNKNOWN = 4'hf
    } except_code_t;

    // One result on the common data bus
    typedef struct packed {
        rob_idx_t                     rob_idx;
        logic [cpu_cfg_pkg::XLEN-1:0] res_value;
        // Secondary result word
        logic [cpu_cfg_pkg::XLEN-1:0] res_aux;
        logic                         except_raised;
        except_code_t                 except_code;
    } cdb_data_t;

    // Which CDB requester wins a tie
    typedef enum logic {
        PRIO_RS  = 1'b0,
        PRIO_EXT = 1'b1
    } prio_t;

endpackage

// File: source/issue_if.sv
// Issue handshake between the issue stage and the station
// One instruction with its first source operand and destination

`timescale 1ns/1ns

interface issue_if;
    // Handshake
    logic                         valid;
    logic                         ready;

    // Operand state and destination
    logic                         rs1_ready;
    expipe_pkg::rob_idx_t         rs1_idx;
    logic [cpu_cfg_pkg::XLEN-1:0] rs1_value;
    expipe_pkg::rob_idx_t         dest_idx;

    // Issue stage side
    modport src (output valid, output rs1_ready, output rs1_idx,
                 output rs1_value, output dest_idx, input ready);
    // Station side
    modport dst (input valid, input rs1_ready, input rs1_idx,
                 input rs1_value, input dest_idx, output ready);
endinterface

// File: source/cdb_if.sv
// Common data bus result channel
// One result with valid/ready handshake and a snooping view

`timescale 1ns/1ns

interface cdb_if;
    logic                  valid;
    logic                  ready;
    expipe_pkg::cdb_data_t data;

    // Producer of results
    modport src (output valid, output data, input ready);
    // Consumer that accepts results
    modport dst (input valid, input data, output ready);
    // Snooper that only watches transfers
    modport mon (input valid, input ready, input data);
endinterface

// File: source/modn_counter.sv
// Modulo-N counter
// Synchronous clear and enable with terminal count flag

`timescale 1ns/1ns

module modn_counter #(
    parameter int unsigned N = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 clr_i,
    output logic [$clog2(N)-1:0] count_o,
    output logic                 tc_o
);

    localparam int unsigned CW = $clog2(N);
    // Last value before wrapping
    localparam logic [CW-1:0] LAST = CW'(N - 1);

    assign tc_o = (count_o == LAST);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            // Clear wins over enable
            count_o <= '0;
        end else if (en_i) begin
            count_o <= tc_o ? '0 : count_o + CW'(1);
        end
    end

endmodule

// File: source/issue_stage.sv
// Issue stage holding register
// One-entry buffer in front of the operand-only station
// Captures a pending operand from the CDB while it waits

`timescale 1ns/1ns

module issue_stage (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         issue_valid_i,
    output logic                         issue_ready_o,
    input  logic                         rs1_ready_i,
    input  expipe_pkg::rob_idx_t         rs1_idx_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0] rs1_value_i,
    input  expipe_pkg::rob_idx_t         dest_idx_i,
    issue_if.src                         iss,
    cdb_if.mon                           bcast
);

    // Held instruction
    logic                         hold_valid;
    logic                         hold_rs1_ready;
    expipe_pkg::rob_idx_t         hold_rs1_idx;
    logic [cpu_cfg_pkg::XLEN-1:0] hold_rs1_value;
    expipe_pkg::rob_idx_t         hold_dest_idx;

    logic bcast_ok;
    logic hold_hit;
    logic in_hit;
    logic push;
    logic leave;

    // ----------------------------------------
    // Operand wakeup
    // ----------------------------------------
    // Only accepted results without exception may wake
    assign bcast_ok = bcast.valid && bcast.ready && !bcast.data.except_raised;
    // Match for the held entry
    assign hold_hit = bcast_ok && hold_valid && !hold_rs1_ready &&
                      (bcast.data.rob_idx == hold_rs1_idx);
    // Match for an instruction arriving this cycle
    assign in_hit = bcast_ok && !rs1_ready_i && (bcast.data.rob_idx == rs1_idx_i);

    // ----------------------------------------
    // Handshakes
    // ----------------------------------------
    assign leave         = hold_valid && iss.ready;
    // Free slot or slot emptying now
    assign issue_ready_o = !hold_valid || iss.ready;
    assign push          = issue_valid_i && issue_ready_o;

    // Offer with this cycle's broadcast merged in
    assign iss.valid     = hold_valid;
    assign iss.rs1_ready = hold_rs1_ready || hold_hit;
    assign iss.rs1_value = hold_hit ? bcast.data.res_value : hold_rs1_value;
    assign iss.rs1_idx   = hold_rs1_idx;
    assign iss.dest_idx  = hold_dest_idx;

    // Status bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_valid     <= 1'b0;
            hold_rs1_ready <= 1'b0;
        end else if (flush_i) begin
            hold_valid     <= 1'b0;
            hold_rs1_ready <= 1'b0;
        end else if (push) begin
            hold_valid     <= 1'b1;
            hold_rs1_ready <= rs1_ready_i || in_hit;
        end else if (leave) begin
            hold_valid     <= 1'b0;
        end else if (hold_hit) begin
            hold_rs1_ready <= 1'b1;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (push) begin
            hold_rs1_idx   <= rs1_idx_i;
            hold_dest_idx  <= dest_idx_i;
            hold_rs1_value <= in_hit ? bcast.data.res_value : rs1_value_i;
        end else if (hold_hit) begin
            hold_rs1_value <= bcast.data.res_value;
        end
    end

    // Stalled entry is never replaced by a new one
    a_hold_kept: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        hold_valid && !iss.ready && !flush_i |=> hold_valid && $stable(hold_dest_idx)
    );

endmodule

// File: source/op_only_rs.sv
// Operand-only reservation station
// In-order circular FIFO of waiting instructions
// Snoops the CDB for operands and releases the head result

`timescale 1ns/1ns

module op_only_rs #(
    parameter int unsigned RS_DEPTH = cpu_cfg_pkg::RS_DEPTH
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    issue_if.dst iss,
    cdb_if.mon   bcast,
    cdb_if.src   res
);

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);

    // Entry status
    logic [RS_DEPTH-1:0]          ent_valid;
    logic [RS_DEPTH-1:0]          ent_ready;
    // Entry payload
    expipe_pkg::rob_idx_t         ent_rs1_idx   [RS_DEPTH];
    logic [cpu_cfg_pkg::XLEN-1:0] ent_rs1_value [RS_DEPTH];
    expipe_pkg::rob_idx_t         ent_dest_idx  [RS_DEPTH];

    // Ring pointers
    logic [IDX_W-1:0]             head_idx;
    logic [IDX_W-1:0]             tail_idx;

    logic                         bcast_ok;
    logic                         push;
    logic                         pop;
    logic [RS_DEPTH-1:0]          wake;

    // ----------------------------------------
    // Snooping
    // ----------------------------------------
    assign bcast_ok = bcast.valid && bcast.ready && !bcast.data.except_raised;

    // Per entry operand match
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake[i] = bcast_ok && ent_valid[i] && !ent_ready[i] &&
                      (ent_rs1_idx[i] == bcast.data.rob_idx);
        end
    end

    // ----------------------------------------
    // Handshakes
    // ----------------------------------------
    // Room as long as the tail slot is free
    assign iss.ready = !ent_valid[tail_idx];
    assign push      = iss.valid && iss.ready;
    // Head with its operand is a finished result
    assign res.valid = ent_valid[head_idx] && ent_ready[head_idx];
    assign pop       = res.valid && res.ready;

    // Status bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
            ent_ready <= '0;
        end else if (flush_i) begin
            ent_valid <= '0;
            ent_ready <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (wake[i]) begin
                    ent_ready[i] <= 1'b1;
                end
            end
            // Offered operand already holds this cycle's broadcast
            if (push) begin
                ent_valid[tail_idx] <= 1'b1;
                ent_ready[tail_idx] <= iss.rs1_ready;
            end
            if (pop) begin
                ent_valid[head_idx] <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake[i]) begin
                ent_rs1_value[i] <= bcast.data.res_value;
            end
        end
        if (push) begin
            ent_rs1_idx[tail_idx]   <= iss.rs1_idx;
            ent_rs1_value[tail_idx] <= iss.rs1_value;
            ent_dest_idx[tail_idx]  <= iss.dest_idx;
        end
    end

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    // Wrap flags not needed for the ring
    modn_counter #(.N(RS_DEPTH)) head_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx),
        .tc_o    ()
    );

    modn_counter #(.N(RS_DEPTH)) tail_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx),
        .tc_o    ()
    );

    // Result is a plain move of the operand
    always_comb begin
        res.data               = '0;
        res.data.rob_idx       = ent_dest_idx[head_idx];
        res.data.res_value     = ent_rs1_value[head_idx];
        res.data.res_aux       = '0;
        res.data.except_raised = 1'b0;
        res.data.except_code   = expipe_pkg::E_NONE;
    end

    // Push lands on a free slot of a consistent ring
    a_push_free: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push |-> !ent_valid[tail_idx] && ((tail_idx != head_idx) || (ent_valid == '0))
    );

    // Offered result holds still until the arbiter takes it
    a_res_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        res.valid && !res.ready && !flush_i |=> res.valid && $stable(res.data)
    );

endmodule

// File: source/cdb_arbiter.sv
// CDB arbiter
// Round-robin choice between the station and the external unit
// Drives the winner onto the broadcast bus

`timescale 1ns/1ns

module cdb_arbiter (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    cdb_if.dst                    rs_res,
    input  logic                  ext_valid_i,
    output logic                  ext_ready_o,
    input  expipe_pkg::cdb_data_t ext_data_i,
    cdb_if.src                    bcast
);

    // Source favoured on a tie
    expipe_pkg::prio_t prio_q;

    logic sel_rs;
    logic sel_ext;

    // ----------------------------------------
    // Selection
    // ----------------------------------------
    // Station wins when alone or when it holds priority
    assign sel_rs  = rs_res.valid &&
                     (!ext_valid_i || (prio_q == expipe_pkg::PRIO_RS));
    assign sel_ext = ext_valid_i && !sel_rs;

    // Bus driven straight from the requests
    assign bcast.valid = rs_res.valid || ext_valid_i;
    assign bcast.data  = sel_rs ? rs_res.data : ext_data_i;

    // Grant only while the bus accepts
    assign rs_res.ready = sel_rs && bcast.ready;
    assign ext_ready_o  = sel_ext && bcast.ready;

    // Served source drops to low priority
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q <= expipe_pkg::PRIO_RS;
        end else if (rs_res.ready) begin
            prio_q <= expipe_pkg::PRIO_EXT;
        end else if (ext_ready_o) begin
            prio_q <= expipe_pkg::PRIO_RS;
        end
    end

    // Never two grants in one cycle
    a_one_grant: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(rs_res.ready && ext_ready_o)
    );

endmodule

// File: source/op_only_cluster.sv
// Operand-only reservation station cluster
// Issue stage, station and CDB arbiter behind plain ports

`timescale 1ns/1ns

module op_only_cluster (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    // Issue side
    input  logic                         issue_valid_i,
    output logic                         issue_ready_o,
    input  logic                         rs1_ready_i,
    input  expipe_pkg::rob_idx_t         rs1_idx_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0] rs1_value_i,
    input  expipe_pkg::rob_idx_t         dest_idx_i,
    // External unit results
    input  logic                         ext_valid_i,
    output logic                         ext_ready_o,
    input  expipe_pkg::cdb_data_t        ext_data_i,
    // CDB out
    output logic                         cdb_valid_o,
    input  logic                         cdb_ready_i,
    output expipe_pkg::cdb_data_t        cdb_data_o
);

    issue_if iss_if ();
    cdb_if   rs_res_if ();
    cdb_if   bcast_if ();

    // Broadcast bus leaves the cluster and is snooped inside
    assign bcast_if.ready = cdb_ready_i;
    assign cdb_valid_o    = bcast_if.valid;
    assign cdb_data_o     = bcast_if.data;

    issue_stage u_issue_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .rs1_ready_i   (rs1_ready_i),
        .rs1_idx_i     (rs1_idx_i),
        .rs1_value_i   (rs1_value_i),
        .dest_idx_i    (dest_idx_i),
        .iss           (iss_if.src),
        .bcast         (bcast_if.mon)
    );

    op_only_rs #(.RS_DEPTH(cpu_cfg_pkg::RS_DEPTH)) u_op_only_rs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .iss     (iss_if.dst),
        .bcast   (bcast_if.mon),
        .res     (rs_res_if.src)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rs_res      (rs_res_if.dst),
        .ext_valid_i (ext_valid_i),
        .ext_ready_o (ext_ready_o),
        .ext_data_i  (ext_data_i),
        .bcast       (bcast_if.src)
    );

endmodule

// File: testbench/tb_op_only_cluster.sv
// Testbench for the operand-only reservation station cluster
// Random stimulus, reference model of CDB results, source order and flush checks

`timescale 1ns/1ns

module tb_op_only_cluster;

    localparam int unsigned XLEN = cpu_cfg_pkg::XLEN;
    // Width of one CDB payload
    localparam int unsigned CDB_W = $bits(expipe_pkg::cdb_data_t);
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 300;

    logic                         clk_i;
    logic                         rst_n_i;
    logic                         flush_i;
    logic                         issue_valid_i;
    logic                         issue_ready_o;
    logic                         rs1_ready_i;
    expipe_pkg::rob_idx_t         rs1_idx_i;
    logic [XLEN-1:0]              rs1_value_i;
    expipe_pkg::rob_idx_t         dest_idx_i;
    logic                         ext_valid_i;
    logic                         ext_ready_o;
    expipe_pkg::cdb_data_t        ext_data_i;
    logic                         cdb_valid_o;
    logic                         cdb_ready_i;
    expipe_pkg::cdb_data_t        cdb_data_o;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    integer                       seed;
    int                           check_errors;
    int                           other_errors;
    // Clean value of each external ROB index
    logic [XLEN-1:0]              ext_val [cpu_cfg_pkg::ROB_DEPTH];
    // Index already broadcast without exception
    logic                         known [cpu_cfg_pkg::ROB_DEPTH];
    // Expected station results in issue order
    expipe_pkg::cdb_data_t        rs_q [$];
    // External results sent but not yet seen
    expipe_pkg::cdb_data_t        ext_q [$];
    // Source of each transfer, 1 for external
    logic                         src_log [$];
    expipe_pkg::cdb_data_t        mon_exp;
    logic                         traffic_done;

    op_only_cluster dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [CDB_W-1:0] got,
                               input logic [CDB_W-1:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Station result as the move rule defines it
    function automatic expipe_pkg::cdb_data_t station_result(input expipe_pkg::rob_idx_t dst,
                                                             input logic [XLEN-1:0] value);
        expipe_pkg::cdb_data_t d;
        d.rob_idx       = dst;
        d.res_value     = value;
        d.res_aux       = '0;
        d.except_raised = 1'b0;
        d.except_code   = expipe_pkg::E_NONE;
        return d;
    endfunction

    // Exception results carry a junk value
    function automatic expipe_pkg::cdb_data_t make_ext(input int idx, input logic exc);
        expipe_pkg::cdb_data_t d;
        d.rob_idx       = expipe_pkg::rob_idx_t'(idx);
        d.res_value     = exc ? $random(seed) : ext_val[idx];
        d.res_aux       = $random(seed);
        d.except_raised = exc;
        d.except_code   = exc ? expipe_pkg::E_ILLEGAL : expipe_pkg::E_NONE;
        return d;
    endfunction

    task automatic send_ext(input expipe_pkg::cdb_data_t item);
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        ext_q.push_back(item);
        ext_valid_i = 1'b1;
        ext_data_i  = item;
        while (!taken && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            taken = ext_ready_o;
            @(posedge clk_i);
            #1;
            cycles++;
        end
        ext_valid_i = 1'b0;
        if (!taken) report_failure("external result was never accepted");
    endtask

    task automatic issue_instr(input logic rdy, input expipe_pkg::rob_idx_t src,
                               input logic [XLEN-1:0] val, input expipe_pkg::rob_idx_t dst);
        int              cycles;
        logic            taken;
        logic [XLEN-1:0] exp_val;
        cycles  = 0;
        taken   = 1'b0;
        exp_val = rdy ? val : ext_val[src];
        issue_valid_i = 1'b1;
        rs1_idx_i     = src;
        dest_idx_i    = dst;
        while (!taken && cycles < WAIT_LIMIT) begin
            // Operand broadcast before the push is handed over as ready
            if (rdy || known[src]) begin
                rs1_ready_i = 1'b1;
                rs1_value_i = exp_val;
            end else begin
                rs1_ready_i = 1'b0;
                rs1_value_i = $random(seed);
            end
            @(negedge clk_i);
            taken = issue_ready_o;
            @(posedge clk_i);
            #1;
            cycles++;
        end
        issue_valid_i = 1'b0;
        if (taken) rs_q.push_back(station_result(dst, exp_val));
        else report_failure("instruction was never accepted by the issue stage");
    endtask

    // Push ready instructions until issue_ready_o drops
    task automatic fill_stalled();
        int              accepted;
        logic            stalled;
        logic [XLEN-1:0] v;
        accepted = 0;
        stalled  = 1'b0;
        while (!stalled && accepted <= cpu_cfg_pkg::RS_DEPTH + 1) begin
            v = $random(seed);
            issue_valid_i = 1'b1;
            rs1_ready_i   = 1'b1;
            rs1_idx_i     = '0;
            rs1_value_i   = v;
            dest_idx_i    = expipe_pkg::rob_idx_t'(12 + accepted % 4);
            @(negedge clk_i);
            if (issue_ready_o) begin
                rs_q.push_back(station_result(dest_idx_i, v));
                accepted++;
            end else begin
                stalled = 1'b1;
            end
            @(posedge clk_i);
            #1;
        end
        issue_valid_i = 1'b0;
        if (!stalled) report_failure("issue_ready_o stayed high past RS_DEPTH+1 acceptances");
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((rs_q.size() != 0 || ext_q.size() != 0 || cdb_valid_o) && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (rs_q.size() != 0 || ext_q.size() != 0) report_failure("expected results never appeared");
    endtask

    // ----------------------------------------
    // CDB monitor
    // ----------------------------------------
    always @(negedge clk_i) begin
        if (rst_n_i && cdb_valid_o && cdb_ready_i) begin
            // Grant to the external port tells the two sources apart
            if (ext_ready_o) begin
                src_log.push_back(1'b1);
                if (ext_q.size() == 0) begin
                    report_failure("external result on the CDB that was never sent");
                end else begin
                    mon_exp = ext_q.pop_front();
                    check_value("external result passed unchanged", cdb_data_o, mon_exp);
                    if (!mon_exp.except_raised) known[mon_exp.rob_idx] = 1'b1;
                end
            end else begin
                src_log.push_back(1'b0);
                if (rs_q.size() == 0) begin
                    report_failure("station result with no pending instruction");
                end else begin
                    mon_exp = rs_q.pop_front();
                    check_value("station result in issue order", cdb_data_o, mon_exp);
                end
            end
        end
        // Flushed instructions never complete
        if (flush_i) rs_q.delete();
    end

    initial begin
        repeat (20000) @(posedge clk_i);
        $display("Simulation stopped by the watchdog before the test finished");
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        expipe_pkg::cdb_data_t held;
        int                    k;
        int                    r;
        expipe_pkg::rob_idx_t  src;
        seed          = 32'h0ecf_5140;
        check_errors  = 0;
        other_errors  = 0;
        traffic_done  = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        rs1_ready_i   = 1'b0;
        rs1_idx_i     = '0;
        rs1_value_i   = '0;
        dest_idx_i    = '0;
        ext_valid_i   = 1'b0;
        ext_data_i    = '0;
        cdb_ready_i   = 1'b0;
        for (k = 0; k < cpu_cfg_pkg::ROB_DEPTH; k++) begin
            ext_val[k] = $random(seed);
            known[k]   = 1'b0;
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("issue ready after reset", issue_ready_o, 1'b1);
        check_value("CDB valid after reset", cdb_valid_o, 1'b0);
        check_value("external ready after reset", ext_ready_o, 1'b0);
        @(posedge clk_i);
        #1;

        // Back-pressure fill, then alternation with both sources busy
        fork
            begin
                for (int i = 0; i < 4; i++) send_ext(make_ext(i, 1'b0));
            end
            begin
                fill_stalled();
                @(negedge clk_i);
                held = cdb_data_o;
                repeat (5) begin
                    @(negedge clk_i);
                    check_value("CDB valid under back-pressure", cdb_valid_o, 1'b1);
                    check_value("CDB data held under back-pressure", cdb_data_o, held);
                end
                @(posedge clk_i);
                #1;
                src_log.delete();
                cdb_ready_i = 1'b1;
                k = 0;
                while (src_log.size() < 8 && k < WAIT_LIMIT) begin
                    @(posedge clk_i);
                    #1;
                    k++;
                end
                if (src_log.size() < 8) begin
                    report_failure("too few CDB transfers while both sources requested");
                end else begin
                    for (k = 0; k < 8; k++) check_value("arbiter source order", src_log[k], k % 2);
                end
            end
        join
        drain();

        // Flush with a full station and an external result pending
        cdb_ready_i = 1'b0;
        fork
            send_ext(make_ext(4, 1'b0));
            begin
                fill_stalled();
                flush_i = 1'b1;
                idle(1);
                flush_i = 1'b0;
                @(negedge clk_i);
                check_value("issue ready after flush", issue_ready_o, 1'b1);
                @(posedge clk_i);
                #1;
                cdb_ready_i = 1'b1;
            end
        join
        idle(10);
        drain();

        // Random traffic with exception results and random back-pressure
        fork
            begin
                fork
                    for (int x = 5; x < 12; x++) begin
                        if ({$random(seed)} % 2 == 0) send_ext(make_ext(x, 1'b1));
                        idle({$random(seed)} % 8);
                        send_ext(make_ext(x, 1'b0));
                    end
                    for (int n = 0; n < 40; n++) begin
                        r   = {$random(seed)} % 4;
                        src = expipe_pkg::rob_idx_t'({$random(seed)} % 12);
                        issue_instr(r == 0, src, $random(seed), expipe_pkg::rob_idx_t'(12 + n % 4));
                        idle({$random(seed)} % 3);
                    end
                join
                traffic_done = 1'b1;
            end
            while (!traffic_done) begin
                @(posedge clk_i);
                #1;
                cdb_ready_i = ({$random(seed)} % 4) != 0;
            end
        join
        cdb_ready_i = 1'b1;
        drain();

        $display("Errors: %0d check failures, %0d other failures", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: op_only_cluster.f
source/cpu_cfg_pkg.sv
source/expipe_pkg.sv
source/issue_if.sv
source/cdb_if.sv
source/modn_counter.sv
source/issue_stage.sv
source/op_only_rs.sv
source/cdb_arbiter.sv
source/op_only_cluster.sv
testbench/tb_op_only_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Build the cluster testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_op_only_cluster -f op_only_cluster.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
